// File: Makefile
VERILATOR ?= verilator
TOP       ?= aes_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
+incdir+include
source/aes_package.sv
source/aes_stream_if.sv
source/aes_regfile.sv
source/aes_fsm.sv
source/aes_streamer.sv
source/aes_engine.sv
source/aes_top.sv
test/aes_assert.sv
test/aes_tb.sv

// File: include/aes_macros.svh
`ifndef AES_MACROS_SVH
`define AES_MACROS_SVH

`define AES_DATA_W      32
`define AES_BLOCK_WORDS 4
`define AES_ROUNDS      4

`define AES_REG_CTRL    'h00
`define AES_REG_STATUS  'h04
`define AES_REG_SRC     'h08
`define AES_REG_DST     'h0C
`define AES_REG_KEY0    'h10

`endif

// File: source/aes_engine.sv
`timescale 1ns/1ps

`include "aes_macros.svh"

module aes_engine (
  input  logic                       clk,
  input  logic                       reset_n,
  input  aes_package::ctrl_engine_t  ctrl_i,
  output aes_package::flags_engine_t flags_o
);

  import aes_package::*;

  localparam int unsigned RND_W = $clog2(`AES_ROUNDS);
  localparam logic [RND_W-1:0] LAST_RND = RND_W'(`AES_ROUNDS - 1);

  logic             busy_q, valid_q;
  logic [RND_W-1:0] rnd_q;
  aes_block_t       state_q, key_q;

  // One round XORs with the key and rotates left by a byte
  function automatic aes_block_t round_f(aes_block_t state, aes_block_t key);
    aes_block_t mixed;
    mixed = state ^ key;
    return {mixed[$bits(aes_block_t)-9:0], mixed[$bits(aes_block_t)-1 -: 8]};
  endfunction

  // First round is applied at load, so valid follows start by AES_ROUNDS cycles
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      rnd_q   <= '0;
    end else begin
      valid_q <= 1'b0;
      if (ctrl_i.clear) begin
        busy_q <= 1'b0;
        rnd_q  <= '0;
      end else if (ctrl_i.start) begin
        busy_q <= 1'b1;
        rnd_q  <= RND_W'(1);
      end else if (busy_q) begin
        rnd_q <= rnd_q + 1'b1;
        if (rnd_q == LAST_RND) begin
          busy_q  <= 1'b0;
          valid_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_i.start) begin
      state_q <= round_f(ctrl_i.block, ctrl_i.key);
      key_q   <= ctrl_i.key;
    end else if (busy_q) begin
      state_q <= round_f(state_q, key_q);
    end
  end

  assign flags_o.busy   = busy_q;
  assign flags_o.valid  = valid_q;
  assign flags_o.result = state_q;

endmodule

// File: source/aes_fsm.sv
`timescale 1ns/1ps

`include "aes_macros.svh"

module aes_fsm (
  input  logic                        clk,
  input  logic                        reset_n,
  input  aes_package::ctrl_regfile_t  regs_i,
  output aes_package::flags_regfile_t flags_o,
  aes_stream_if.ctrl                  stream,
  output aes_package::ctrl_engine_t   engine_o,
  input  aes_package::flags_engine_t  engine_i
);

  import aes_package::*;

  localparam int unsigned DATA_W = `AES_DATA_W;
  localparam int unsigned CNT_W  = $clog2(`AES_BLOCK_WORDS);
  localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`AES_BLOCK_WORDS - 1);

  aes_state_t                                   current_state, next_state;
  logic [CNT_W-1:0]                             word_cnt;
  logic                                         word_done;
  logic [DATA_W-1:0]                            base_addr;
  logic [`AES_BLOCK_WORDS-1:0][`AES_DATA_W-1:0] block_q, result_q;

  assign word_done = stream.done &&
                     (current_state == REQUEST_DATA_WAIT || current_state == SEND_DATA_WAIT);

  always_ff @(posedge clk or negedge reset_n) begin : fsm_seq_state
    if (!reset_n)
      current_state <= IDLE;
    else
      current_state <= next_state;
  end

  // Word index within the block that wraps after the last word
  always_ff @(posedge clk or negedge reset_n) begin : fsm_seq_counter
    if (!reset_n)
      word_cnt <= '0;
    else if (current_state == IDLE)
      word_cnt <= '0;
    else if (word_done)
      word_cnt <= word_cnt + 1'b1;
  end

  always_ff @(posedge clk) begin : fsm_seq_data
    if (current_state == REQUEST_DATA_WAIT && stream.done)
      block_q[word_cnt] <= stream.rdata;
    if (current_state == WORKING && engine_i.valid)
      result_q <= engine_i.result;
  end

  always_comb begin : fsm_comb_next_state
    next_state = current_state;
    case (current_state)
      IDLE:              if (regs_i.start) next_state = REQUEST_DATA;
      REQUEST_DATA:      if (stream.ready) next_state = REQUEST_DATA_WAIT;
      REQUEST_DATA_WAIT: begin
        if (stream.done)
          next_state = (word_cnt == LAST_WORD) ? WORKING : REQUEST_DATA;
      end
      WORKING:           if (engine_i.valid) next_state = SEND_DATA;
      SEND_DATA:         if (stream.ready) next_state = SEND_DATA_WAIT;
      SEND_DATA_WAIT: begin
        if (stream.done)
          next_state = (word_cnt == LAST_WORD) ? FINISHED : SEND_DATA;
      end
      FINISHED:          next_state = IDLE;
      default:           next_state = IDLE;
    endcase
  end

  // Transfer address from base plus 4 times the word index
  assign base_addr = (current_state == SEND_DATA) ? regs_i.dst : regs_i.src;

  assign stream.req_start = (current_state == REQUEST_DATA) || (current_state == SEND_DATA);
  assign stream.write     = current_state == SEND_DATA;
  assign stream.addr      = base_addr + DATA_W'({word_cnt, 2'b00});
  assign stream.wdata     = result_q[word_cnt];

  // Single start pulse on entry to WORKING while the engine is idle
  assign engine_o.start = (current_state == WORKING) && !engine_i.busy && !engine_i.valid;
  assign engine_o.clear = current_state == IDLE;
  assign engine_o.key   = regs_i.key;
  assign engine_o.block = block_q;

  assign flags_o.busy = current_state != IDLE;
  assign flags_o.done = current_state == FINISHED;

endmodule

// File: source/aes_package.sv
`include "aes_macros.svh"

package aes_package;

  // One full cipher block with word 0 in the low bits
  typedef logic [`AES_DATA_W*`AES_BLOCK_WORDS-1:0] aes_block_t;

  typedef enum logic [2:0] {
    IDLE,
    REQUEST_DATA,
    REQUEST_DATA_WAIT,
    WORKING,
    SEND_DATA,
    SEND_DATA_WAIT,
    FINISHED
  } aes_state_t;

  typedef struct packed {
    logic       start;
    logic       clear;
    aes_block_t key;
    aes_block_t block;
  } ctrl_engine_t;

  typedef struct packed {
    logic       busy;
    logic       valid;
    aes_block_t result;
  } flags_engine_t;

  // Job setup as seen by the controller
  typedef struct packed {
    logic                   start;
    logic [`AES_DATA_W-1:0] src;
    logic [`AES_DATA_W-1:0] dst;
    aes_block_t             key;
  } ctrl_regfile_t;

  typedef struct packed {
    logic busy;
    logic done;
  } flags_regfile_t;

endpackage

// File: source/aes_regfile.sv
`timescale 1ns/1ps

`include "aes_macros.svh"

module aes_regfile (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         apb_psel_i,
  input  logic                         apb_penable_i,
  input  logic                         apb_pwrite_i,
  input  logic [`AES_DATA_W-1:0]       apb_paddr_i,
  input  logic [`AES_DATA_W-1:0]       apb_pwdata_i,
  output logic [`AES_DATA_W-1:0]       apb_prdata_o,
  output logic                         apb_pready_o,
  output logic                         apb_pslverr_o,
  input  aes_package::flags_regfile_t  flags_i,
  output aes_package::ctrl_regfile_t   regs_o,
  output logic                         irq_o
);

  localparam int unsigned DATA_W = `AES_DATA_W;
  localparam int unsigned IDX_W  = $clog2(`AES_BLOCK_WORDS);

  logic                                         wr_en;
  logic                                         ctrl_hit, status_hit, src_hit, dst_hit, key_hit;
  logic [DATA_W-1:0]                            key_off;
  logic [IDX_W-1:0]                             key_idx;
  logic                                         start_q, done_q;
  logic [DATA_W-1:0]                            src_q, dst_q;
  logic [`AES_BLOCK_WORDS-1:0][`AES_DATA_W-1:0] key_q;

  // Address decode
  assign ctrl_hit   = apb_paddr_i == `AES_REG_CTRL;
  assign status_hit = apb_paddr_i == `AES_REG_STATUS;
  assign src_hit    = apb_paddr_i == `AES_REG_SRC;
  assign dst_hit    = apb_paddr_i == `AES_REG_DST;
  assign key_off    = apb_paddr_i - `AES_REG_KEY0;
  assign key_hit    = (key_off < DATA_W'(`AES_BLOCK_WORDS * 4)) && (key_off[1:0] == 2'b00);
  assign key_idx    = key_off[IDX_W+1:2];

  assign wr_en         = apb_psel_i & apb_penable_i & apb_pwrite_i;
  assign apb_pready_o  = 1'b1;
  assign apb_pslverr_o = apb_psel_i & apb_penable_i &
                         ~(ctrl_hit | status_hit | src_hit | dst_hit | key_hit);

  // Start pulse and sticky done
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      start_q <= wr_en & ctrl_hit & apb_pwdata_i[0] & ~flags_i.busy;
      if (flags_i.done)
        done_q <= 1'b1;
      else if (start_q)
        done_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && src_hit)
      src_q <= apb_pwdata_i;
    if (wr_en && dst_hit)
      dst_q <= apb_pwdata_i;
    if (wr_en && key_hit)
      key_q[key_idx] <= apb_pwdata_i;
  end

  // Read mux where CTRL reads back as zero
  always_comb begin
    apb_prdata_o = '0;
    if (status_hit)
      apb_prdata_o[1:0] = {done_q, flags_i.busy};
    else if (src_hit)
      apb_prdata_o = src_q;
    else if (dst_hit)
      apb_prdata_o = dst_q;
    else if (key_hit)
      apb_prdata_o = key_q[key_idx];
  end

  assign regs_o.start = start_q;
  assign regs_o.src   = src_q;
  assign regs_o.dst   = dst_q;
  assign regs_o.key   = key_q;
  assign irq_o        = done_q;

endmodule

// File: source/aes_stream_if.sv
`timescale 1ns/1ps

`include "aes_macros.svh"

interface aes_stream_if;

  logic                   req_start;
  logic                   write;
  logic [`AES_DATA_W-1:0] addr;
  logic [`AES_DATA_W-1:0] wdata;
  logic                   ready;
  logic                   done;
  logic [`AES_DATA_W-1:0] rdata;

  modport ctrl (output req_start, output write, output addr, output wdata,
                input ready, input done, input rdata);

  modport stream (input req_start, input write, input addr, input wdata,
                  output ready, output done, output rdata);

endinterface

// File: source/aes_streamer.sv
`timescale 1ns/1ps

`include "aes_macros.svh"

module aes_streamer (
  input  logic                   clk,
  input  logic                   reset_n,
  aes_stream_if.stream           stream,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output logic [`AES_DATA_W-1:0] mem_addr_o,
  output logic [`AES_DATA_W-1:0] mem_wdata_o,
  input  logic                   mem_gnt_i,
  input  logic [`AES_DATA_W-1:0] mem_rdata_i,
  input  logic                   mem_rvalid_i
);

  logic                   accept;
  logic                   req_q, rsp_q, we_q, done_q;
  logic [`AES_DATA_W-1:0] addr_q, wdata_q, rdata_q;

  assign accept = stream.req_start & stream.ready;

  // Request held until grant and a read then waits for rvalid
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      req_q  <= 1'b0;
      rsp_q  <= 1'b0;
      we_q   <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= (req_q & mem_gnt_i & we_q) | (rsp_q & mem_rvalid_i);
      if (accept) begin
        req_q <= 1'b1;
        we_q  <= stream.write;
      end else if (req_q && mem_gnt_i) begin
        req_q <= 1'b0;
        rsp_q <= ~we_q;
      end else if (rsp_q && mem_rvalid_i) begin
        rsp_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= stream.addr;
      wdata_q <= stream.wdata;
    end
    if (rsp_q && mem_rvalid_i)
      rdata_q <= mem_rdata_i;
  end

  assign stream.ready = ~(req_q | rsp_q);
  assign stream.done  = done_q;
  assign stream.rdata = rdata_q;

  assign mem_req_o   = req_q;
  assign mem_we_o    = we_q;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = wdata_q;

endmodule

// File: source/aes_top.sv
`timescale 1ns/1ps

`include "aes_macros.svh"

module aes_top (
  input  logic                   clk,
  input  logic                   reset_n,
  // APB slave
  input  logic                   apb_psel_i,
  input  logic                   apb_penable_i,
  input  logic                   apb_pwrite_i,
  input  logic [`AES_DATA_W-1:0] apb_paddr_i,
  input  logic [`AES_DATA_W-1:0] apb_pwdata_i,
  output logic [`AES_DATA_W-1:0] apb_prdata_o,
  output logic                   apb_pready_o,
  output logic                   apb_pslverr_o,
  // Memory port
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output logic [`AES_DATA_W-1:0] mem_addr_o,
  output logic [`AES_DATA_W-1:0] mem_wdata_o,
  input  logic                   mem_gnt_i,
  input  logic [`AES_DATA_W-1:0] mem_rdata_i,
  input  logic                   mem_rvalid_i,
  output logic                   irq_o
);

  import aes_package::*;

  ctrl_regfile_t  regs;
  flags_regfile_t regfile_flags;
  ctrl_engine_t   engine_ctrl;
  flags_engine_t  engine_flags;

  aes_stream_if stream_if ();

  aes_regfile regfile_inst (
    .clk           (clk),
    .reset_n       (reset_n),
    .apb_psel_i    (apb_psel_i),
    .apb_penable_i (apb_penable_i),
    .apb_pwrite_i  (apb_pwrite_i),
    .apb_paddr_i   (apb_paddr_i),
    .apb_pwdata_i  (apb_pwdata_i),
    .apb_prdata_o  (apb_prdata_o),
    .apb_pready_o  (apb_pready_o),
    .apb_pslverr_o (apb_pslverr_o),
    .flags_i       (regfile_flags),
    .regs_o        (regs),
    .irq_o         (irq_o)
  );

  aes_fsm fsm_inst (
    .clk      (clk),
    .reset_n  (reset_n),
    .regs_i   (regs),
    .flags_o  (regfile_flags),
    .stream   (stream_if.ctrl),
    .engine_o (engine_ctrl),
    .engine_i (engine_flags)
  );

  aes_streamer streamer_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .stream       (stream_if.stream),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_rvalid_i (mem_rvalid_i)
  );

  aes_engine engine_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .ctrl_i  (engine_ctrl),
    .flags_o (engine_flags)
  );

endmodule

// File: test/aes_assert.sv
`timescale 1ns/1ps

`include "aes_macros.svh"

module aes_assert (
  input logic                        clk,
  input logic                        reset_n,
  input logic                        mem_req_i,
  input logic                        mem_we_i,
  input logic [`AES_DATA_W-1:0]      mem_addr_i,
  input logic [`AES_DATA_W-1:0]      mem_wdata_i,
  input logic                        mem_gnt_i,
  input logic                        apb_pready_i,
  input logic                        irq_i,
  input aes_package::aes_state_t     fsm_state_i
);

  import aes_package::*;

  // A held request keeps address, direction and data until grant
  req_stable: assert property (@(posedge clk) disable iff (!reset_n)
    mem_req_i && !mem_gnt_i |=> mem_req_i && $stable(mem_addr_i) &&
                                $stable(mem_we_i) && $stable(mem_wdata_i))
    else $error("memory request dropped or changed before grant");

  pready_high: assert property (@(posedge clk) disable iff (!reset_n)
    apb_pready_i)
    else $error("APB pready went low");

  // Interrupt stays quiet for the whole job
  irq_quiet: assert property (@(posedge clk) disable iff (!reset_n)
    fsm_state_i != IDLE |-> !irq_i)
    else $error("interrupt high while the controller is busy");

endmodule

bind aes_top aes_assert aes_assert_inst (
  .clk          (clk),
  .reset_n      (reset_n),
  .mem_req_i    (mem_req_o),
  .mem_we_i     (mem_we_o),
  .mem_addr_i   (mem_addr_o),
  .mem_wdata_i  (mem_wdata_o),
  .mem_gnt_i    (mem_gnt_i),
  .apb_pready_i (apb_pready_o),
  .irq_i        (irq_o),
  .fsm_state_i  (fsm_inst.current_state)
);

// File: test/aes_tb.sv
`timescale 1ns/1ps

`include "aes_macros.svh"

module aes_tb;

  import aes_package::*;

  logic                   clk = 1'b0;
  logic                   reset_n;
  logic                   apb_psel;
  logic                   apb_penable;
  logic                   apb_pwrite;
  logic [`AES_DATA_W-1:0] apb_paddr;
  logic [`AES_DATA_W-1:0] apb_pwdata;
  logic [`AES_DATA_W-1:0] apb_prdata;
  logic                   apb_pready;
  logic                   apb_pslverr;
  logic                   mem_req;
  logic                   mem_we;
  logic [`AES_DATA_W-1:0] mem_addr;
  logic [`AES_DATA_W-1:0] mem_wdata;
  logic                   mem_gnt = 1'b0;
  logic [`AES_DATA_W-1:0] mem_rdata = '0;
  logic                   mem_rvalid = 1'b0;
  logic                   irq;

  integer                 seed = 32'h9172;
  logic [`AES_DATA_W-1:0] salt;
  logic [`AES_DATA_W-1:0] mem [0:255];
  int unsigned            write_count = 0;

  always #10 clk = ~clk;

  aes_top aes_top_inst (
    .clk           (clk),
    .reset_n       (reset_n),
    .apb_psel_i    (apb_psel),
    .apb_penable_i (apb_penable),
    .apb_pwrite_i  (apb_pwrite),
    .apb_paddr_i   (apb_paddr),
    .apb_pwdata_i  (apb_pwdata),
    .apb_prdata_o  (apb_prdata),
    .apb_pready_o  (apb_pready),
    .apb_pslverr_o (apb_pslverr),
    .mem_req_o     (mem_req),
    .mem_we_o      (mem_we),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_gnt_i     (mem_gnt),
    .mem_rdata_i   (mem_rdata),
    .mem_rvalid_i  (mem_rvalid),
    .irq_o         (irq)
  );

  function automatic logic [`AES_DATA_W-1:0] fill_word(input logic [7:0] idx);
    return (32'(idx) * 32'h9E37_79B9) ^ salt;
  endfunction

  // Expected cipher with a key XOR and a one-byte left rotate per round
  function automatic aes_block_t cipher_ref(input aes_block_t block, input aes_block_t key);
    aes_block_t s;
    int         r;
    s = block;
    for (r = 0; r < `AES_ROUNDS; r++) begin
      s = s ^ key;
      s = (s << 8) | (s >> ($bits(aes_block_t) - 8));
    end
    return s;
  endfunction

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %0t: %s, got %08h expected %08h", $time, what, actual, expected);
      $display("Some tests failed");
      $fatal(1, "Value mismatch on %s", what);
    end
  endtask

  // Memory with random grant stalls and read data one cycle after grant
  always @(posedge clk) begin : memory_model
    int k;
    if (!reset_n) begin
      for (k = 0; k < 256; k++)
        mem[k] = fill_word(8'(k));
      mem_gnt    <= 1'b0;
      mem_rvalid <= 1'b0;
    end else begin
      mem_gnt    <= 1'b0;
      mem_rvalid <= 1'b0;
      if (mem_req && mem_gnt) begin
        if (mem_we) begin
          mem[mem_addr[9:2]] = mem_wdata;
          write_count++;
        end else begin
          mem_rdata  <= mem[mem_addr[9:2]];
          mem_rvalid <= 1'b1;
        end
      end else if (mem_req && (($random(seed) & 32'h3) == 0)) begin
        mem_gnt <= 1'b1;
      end
    end
  end

  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
    @(posedge clk);
    apb_psel    <= 1'b1;
    apb_penable <= 1'b0;
    apb_pwrite  <= write;
    apb_paddr   <= addr;
    apb_pwdata  <= wdata;
    @(posedge clk);
    apb_penable <= 1'b1;
    @(negedge clk);
    rdata  = apb_prdata;
    slverr = apb_pslverr;
    check_value("pready in access phase", {31'b0, apb_pready}, 32'h1);
    @(posedge clk);
    apb_psel    <= 1'b0;
    apb_penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    logic        slverr;
    apb_transfer(1'b1, addr, wdata, unused, slverr);
    check_value("pslverr on write", {31'b0, slverr}, 32'h0);
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata);
    logic slverr;
    apb_transfer(1'b0, addr, 32'h0, rdata, slverr);
    check_value("pslverr on read", {31'b0, slverr}, 32'h0);
  endtask

  task automatic wait_for_irq(input int unsigned limit);
    int unsigned cycles;
    cycles = 0;
    while (irq !== 1'b1) begin
      if (cycles == limit) begin
        $display("Some tests failed");
        $fatal(1, "Timeout: irq_o did not rise within %0d cycles", limit);
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // One job from src to dst with an optional second start while busy
  task automatic run_job(input logic [31:0] src, input logic [31:0] dst, input bit extra_start);
    aes_block_t  key;
    aes_block_t  plain;
    aes_block_t  expected;
    logic [31:0] rdata;
    logic [7:0]  idx;
    int unsigned writes_before;
    int          i;
    for (i = 0; i < `AES_BLOCK_WORDS; i++) begin
      idx = src[9:2] + 8'(i);
      key[32*i +: 32]   = $random(seed);
      plain[32*i +: 32] = mem[idx];
    end
    apb_write(`AES_REG_SRC, src);
    apb_write(`AES_REG_DST, dst);
    for (i = 0; i < `AES_BLOCK_WORDS; i++)
      apb_write(`AES_REG_KEY0 + 4 * i, key[32*i +: 32]);
    writes_before = write_count;
    apb_write(`AES_REG_CTRL, 32'h1);
    apb_read(`AES_REG_STATUS, rdata);
    check_value("STATUS during job", rdata, 32'h1);
    check_value("irq_o during job", {31'b0, irq}, 32'h0);
    if (extra_start)
      apb_write(`AES_REG_CTRL, 32'h1);
    wait_for_irq(2000);
    if (extra_start)
      repeat (40) @(posedge clk);
    apb_read(`AES_REG_STATUS, rdata);
    check_value("STATUS after job", rdata, 32'h2);
    check_value("irq_o after job", {31'b0, irq}, 32'h1);
    expected = cipher_ref(plain, key);
    for (i = 0; i < `AES_BLOCK_WORDS; i++) begin
      idx = dst[9:2] + 8'(i);
      check_value("result word", mem[idx], expected[32*i +: 32]);
      idx = src[9:2] + 8'(i);
      check_value("plaintext word", mem[idx], plain[32*i +: 32]);
    end
    check_value("memory writes per job", write_count - writes_before, 32'd4);
  endtask

  initial begin : stimulus
    logic [31:0] rdata;
    logic [31:0] wval;
    logic        slverr;
    int          i;
    salt        = $random(seed);
    reset_n     = 1'b0;
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
    apb_pwrite  = 1'b0;
    apb_paddr   = '0;
    apb_pwdata  = '0;
    repeat (16) @(posedge clk);
    reset_n <= 1'b1;

    // Quiet after reset
    repeat (10) begin
      @(negedge clk);
      check_value("mem_req_o after reset", {31'b0, mem_req}, 32'h0);
      check_value("irq_o after reset", {31'b0, irq}, 32'h0);
    end
    apb_read(`AES_REG_STATUS, rdata);
    check_value("STATUS after reset", rdata, 32'h0);

    // Register read-back
    apb_write(`AES_REG_SRC, 32'h0000_0124);
    apb_read(`AES_REG_SRC, rdata);
    check_value("SRC read-back", rdata, 32'h0000_0124);
    apb_write(`AES_REG_DST, 32'h0000_0368);
    apb_read(`AES_REG_DST, rdata);
    check_value("DST read-back", rdata, 32'h0000_0368);
    for (i = 0; i < `AES_BLOCK_WORDS; i++) begin
      wval = $random(seed);
      apb_write(`AES_REG_KEY0 + 4 * i, wval);
      apb_read(`AES_REG_KEY0 + 4 * i, rdata);
      check_value("KEY read-back", rdata, wval);
    end
    apb_transfer(1'b0, 32'h0000_0020, 32'h0, rdata, slverr);
    check_value("pslverr on unmapped offset", {31'b0, slverr}, 32'h1);

    // Single job and then back-to-back jobs under grant stalls
    run_job(32'h000, 32'h200, 1'b0);
    for (i = 1; i < 5; i++)
      run_job(32'h40 * i, 32'h200 + 32'h40 * i, 1'b0);
    run_job(32'h140, 32'h340, 1'b1);

    $display("All tests passed");
    $finish;
  end

endmodule
